//--- src.f
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_shift_sub.sv
logic/div_result_fix.sv
logic/div_ctrl.sv
logic/div_axil_regs.sv
logic/div_axil_top.sv
testbench/div_tb.sv

//--- testbench/div_tb.sv
`timescale 1ns/1ps

module div_tb
    import div_pkg::*;
();

    // about 240 operations of 66 cycles plus up to 100 cycles of bus traffic each.
    localparam int max_cycles = 240 * (66 + 100);

    typedef struct packed {
        div_cmd_t        cmd;
        logic [xlen-1:0] got;
    } obs_t;

    logic                 clk, arst_n;
    logic [axil_aw-1:0]   awaddr, araddr;
    logic                 awvalid, wvalid, bready, arvalid, rready;
    logic [axil_dw-1:0]   wdata;
    logic [axil_dw/8-1:0] wstrb;
    logic                 awready, wready, bvalid, arready, rvalid;
    logic [1:0]           bresp, rresp;
    logic [axil_dw-1:0]   rdata;

    logic [15:0] lfsr_q = 16'd38344;
    logic        stall_en = 1'b0;
    obs_t        obs_q[$];
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_base = 0;
    int          cycles = 0;

    div_axil_top u_div_axil_top (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

    always #4 clk = !clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // riscv M-extension semantics, word forms work on sign/zero extended low halves.
    function automatic logic [63:0] ref_div(input logic [63:0] a, input logic [63:0] b,
                                            input logic [1:0] op, input logic is_w);
        logic [63:0] x, y, q, r, res;
        longint      sx, sy;
        logic        sgn;
        sgn = !op[0];
        x = is_w ? {{32{sgn & a[31]}}, a[31:0]} : a;
        y = is_w ? {{32{sgn & b[31]}}, b[31:0]} : b;
        sx = x;
        sy = y;
        if (y == 0) begin
            q = '1;
            r = x;
        end else if (sgn && x == 64'h8000_0000_0000_0000 && y == '1) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = sx / sy;
            r = sx % sy;  // truncating, sign of dividend.
        end else begin
            q = x / y;
            r = x % y;
        end
        res = op[1] ? r : q;
        return is_w ? {{32{res[31]}}, res[31:0]} : res;
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        logic aw_hs, w_hs;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;   // ready depends on registers only.
            w_hs  = wvalid && wready;
            wait_cycles(1);
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
        wait_cycles(stall_en ? int'(rand_bits(2)) : 0);
        bready = 1'b1;
        while (!bvalid) wait_cycles(1);
        resp = bresp;
        wait_cycles(1);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic ar_hs;
        araddr  = addr;
        arvalid = 1'b1;
        ar_hs   = 1'b0;
        while (!ar_hs) begin
            ar_hs = arready;
            wait_cycles(1);
        end
        arvalid = 1'b0;
        wait_cycles(stall_en ? int'(rand_bits(2)) : 0);
        rready = 1'b1;
        while (!rvalid) wait_cycles(1);
        data = rdata;
        resp = rresp;
        wait_cycles(1);
        rready = 1'b0;
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        n_checks++;
        assert (got == exp) else begin
            $display("%s: response was %0d instead of %0d", what, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s expected %h observed %h", $time, what, exp, got);
            n_errors++;
        end
    endtask

    task automatic start_op(input div_cmd_t cmd);
        logic [1:0] resp;
        axil_write(reg_src1_lo, cmd.src1[31:0], 4'hF, resp);
        check_resp(resp, axil_resp_ok, "write of src1_lo");
        axil_write(reg_src1_hi, cmd.src1[63:32], 4'hF, resp);
        check_resp(resp, axil_resp_ok, "write of src1_hi");
        axil_write(reg_src2_lo, cmd.src2[31:0], 4'hF, resp);
        check_resp(resp, axil_resp_ok, "write of src2_lo");
        axil_write(reg_src2_hi, cmd.src2[63:32], 4'hF, resp);
        check_resp(resp, axil_resp_ok, "write of src2_hi");
        axil_write(reg_ctrl, {29'd0, cmd.is_w, cmd.op}, 4'hF, resp);
        check_resp(resp, axil_resp_ok, "write of ctrl while idle");
    endtask

    task automatic collect_op(input div_cmd_t cmd);
        logic [31:0] status, lo, hi;
        logic [1:0]  resp;
        obs_t        item;
        do begin
            axil_read(reg_status, status, resp);
        end while (!status[1]);
        axil_read(reg_res_lo, lo, resp);
        axil_read(reg_res_hi, hi, resp);
        item.cmd = cmd;
        item.got = {hi, lo};
        obs_q.push_back(item);
    endtask

    task automatic run_op(input logic [63:0] a, input logic [63:0] b,
                          input logic [1:0] op, input logic is_w);
        div_cmd_t cmd;
        cmd.src1 = a;
        cmd.src2 = b;
        cmd.op   = div_op_e'(op);
        cmd.is_w = is_w;
        start_op(cmd);
        collect_op(cmd);
    endtask

    task automatic end_test(input string name);
        while (obs_q.size() > 0) wait_cycles(1);
        $display("test %s done, %0d errors", name, n_errors - test_base);
        test_base = n_errors;
    endtask

    always @(posedge clk) begin
        obs_t        item;
        logic [63:0] exp;
        if (obs_q.size() > 0) begin
            item = obs_q.pop_front();
            exp  = ref_div(item.cmd.src1, item.cmd.src2, item.cmd.op, item.cmd.is_w);
            n_checks++;
            assert (item.got == exp) else begin
                $display("MISMATCH at %0t: src1 %h src2 %h op %0d w %0b expected %h observed %h",
                         $time, item.cmd.src1, item.cmd.src2, item.cmd.op, item.cmd.is_w,
                         exp, item.got);
                n_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        div_cmd_t    cmd;
        clk = 1'b0;
        arst_n = 1'b0;
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        wait_cycles(8);
        arst_n = 1'b1;
        wait_cycles(1);

        axil_read(reg_status, data, resp);
        check_value(data, 32'd0, "status after reset");
        axil_read(reg_res_lo, data, resp);
        check_value(data, 32'd0, "res_lo after reset");
        axil_read(reg_res_hi, data, resp);
        check_value(data, 32'd0, "res_hi after reset");
        run_op(64'd100, 64'd7, op_div, 1'b0);
        run_op(-64'd100, 64'd7, op_div, 1'b0);
        run_op(64'd100, -64'd7, op_rem, 1'b0);
        run_op(-64'd100, -64'd7, op_rem, 1'b0);
        run_op(64'hFFFF_FFFF_FFFF_FFF0, 64'd3, op_divu, 1'b0);
        run_op(64'hFEDC_BA98_7654_3210, 64'h0000_0001_2345_6789, op_remu, 1'b0);
        end_test("directed 64-bit");

        run_op(64'hDEAD_BEEF_FFFF_FFF9, 64'h1234_5678_0000_0002, op_div, 1'b1);
        run_op(64'h0000_0000_FFFF_FFFF, 64'd1, op_divu, 1'b1);
        run_op(64'hABCD_0000_9000_0000, 64'h0000_0001_0000_0001, op_divu, 1'b1);
        run_op(64'd7, 64'h0000_0000_FFFF_FFFD, op_rem, 1'b1);
        run_op(64'h0000_0000_FFFF_FFF7, 64'd4, op_rem, 1'b1);
        run_op(64'h5555_5555_8000_0001, 64'h7777_7777_0000_0003, op_remu, 1'b1);
        end_test("word forms");

        for (int k = 0; k < 8; k++) begin
            run_op(64'h8765_4321_FEDC_BA98, 64'd0, k[1:0], k[2]);
        end
        run_op(64'h8765_4321_FEDC_BA98, 64'hFFFF_FFFF_0000_0000, op_rem, 1'b1);
        run_op(64'h8000_0000_0000_0000, '1, op_div, 1'b0);
        run_op(64'h8000_0000_0000_0000, '1, op_rem, 1'b0);
        run_op(64'h0000_0000_8000_0000, 64'h0000_0000_FFFF_FFFF, op_div, 1'b1);
        run_op(64'h0000_0000_8000_0000, 64'h0000_0000_FFFF_FFFF, op_rem, 1'b1);
        run_op(64'd0, 64'd13, op_div, 1'b0);
        run_op(64'd0, -64'd5, op_remu, 1'b1);
        run_op(64'h1357_9BDF_2468_ACE0, 64'h1357_9BDF_2468_ACE0, op_divu, 1'b0);
        run_op(-64'd12345, -64'd12345, op_rem, 1'b0);
        end_test("corner cases");

        stall_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            // shifting the divisor down gives quotients of every size.
            run_op(rand_bits(64), rand_bits(64) >> rand_bits(6),
                   2'(rand_bits(2)), 1'(rand_bits(1)));
        end
        stall_en = 1'b0;
        end_test("random");

        cmd.src1 = 64'hC000_0000_0000_0123;
        cmd.src2 = 64'd77;
        cmd.op   = op_div;
        cmd.is_w = 1'b0;
        start_op(cmd);
        axil_write(reg_ctrl, 32'h3, 4'hF, resp);
        check_resp(resp, axil_resp_slverr, "write to ctrl while busy");
        collect_op(cmd);
        end_test("busy rejection");

        axil_write(reg_status, 32'h3, 4'hF, resp);
        check_resp(resp, axil_resp_slverr, "write to status");
        axil_read(reg_ctrl, data, resp);
        check_resp(resp, axil_resp_slverr, "read of ctrl");
        axil_write(reg_src1_lo, 32'h1122_3344, 4'hF, resp);
        axil_write(reg_src1_lo, 32'hAABB_CCDD, 4'b0101, resp);
        axil_read(reg_src1_lo, data, resp);
        check_value(data, 32'h11BB_33DD, "src1_lo after partial strobe");
        axil_write(reg_src2_hi, 32'h0F0F_0F0F, 4'hF, resp);
        axil_write(reg_src2_hi, 32'hF0F0_F0F0, 4'b1000, resp);
        axil_read(reg_src2_hi, data, resp);
        check_value(data, 32'hF00F_0F0F, "src2_hi after partial strobe");
        end_test("register access");

        $display("checks passed %0d, failed %0d", n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/div_axil_top.sv
`timescale 1ns/1ps

module div_axil_top
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [axil_aw-1:0]   awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [axil_dw-1:0]   wdata,
    input  logic [axil_dw/8-1:0] wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  logic                 bready,
    input  logic [axil_aw-1:0]   araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    output logic [axil_dw-1:0]   rdata,
    output logic [1:0]           rresp,
    input  logic                 rready
);

    logic            start, load, step, finish, busy, done;
    logic [xlen-1:0] quotient, remainder, result;
    div_cmd_t        cmd;
    div_prep_t       prep, meta;

    div_axil_regs u_regs (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .busy(busy), .done(done), .result(result), .start(start), .cmd(cmd)
    );

    div_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n), .start(start), .load(load),
        .step(step), .finish(finish), .busy(busy), .done(done)
    );

    div_operand_prep u_prep (.cmd(cmd), .prep(prep));

    div_shift_sub u_shift_sub (
        .clk(clk), .arst_n(arst_n), .load(load), .step(step), .prep(prep),
        .quotient(quotient), .remainder(remainder), .meta(meta)
    );

    div_result_fix u_result_fix (
        .clk(clk), .arst_n(arst_n), .finish(finish), .quotient(quotient),
        .remainder(remainder), .meta(meta), .result(result)
    );

endmodule

//--- logic/div_axil_regs.sv
`timescale 1ns/1ps

module div_axil_regs
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [axil_aw-1:0]   awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [axil_dw-1:0]   wdata,
    input  logic [axil_dw/8-1:0] wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  logic                 bready,
    input  logic [axil_aw-1:0]   araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    output logic [axil_dw-1:0]   rdata,
    output logic [1:0]           rresp,
    input  logic                 rready,
    input  logic                 busy,
    input  logic                 done,
    input  logic [xlen-1:0]      result,
    output logic                 start,
    output div_cmd_t             cmd
);

    logic                 aw_full, w_full;
    logic [axil_aw-1:0]   aw_addr_q;
    logic [axil_dw-1:0]   w_data_q;
    logic [axil_dw/8-1:0] w_strb_q;
    logic [axil_dw-1:0]   src1_lo, src1_hi, src2_lo, src2_hi;
    logic [axil_aw-1:0]   wa, ra;
    logic                 wr_fire, wr_err;

    function automatic logic [axil_dw-1:0] strb_merge(input logic [axil_dw-1:0] old_val,
                                                      input logic [axil_dw-1:0] new_val,
                                                      input logic [axil_dw/8-1:0] strb);
        logic [axil_dw-1:0] res;
        res = old_val;
        for (int i = 0; i < axil_dw/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign awready = !aw_full && !bvalid;
    assign wready  = !w_full && !bvalid;
    assign arready = !rvalid;
    assign wa      = {aw_addr_q[axil_aw-1:2], 2'b00};
    assign ra      = {araddr[axil_aw-1:2], 2'b00};
    assign wr_fire = aw_full && w_full && !bvalid; // both channels in hand.
    assign start   = wr_fire && (wa == reg_ctrl) && !busy;

    always_comb begin
        case (wa)
            reg_src1_lo, reg_src1_hi, reg_src2_lo, reg_src2_hi: wr_err = 1'b0;
            reg_ctrl: wr_err = busy;  // no second operation in flight.
            default:  wr_err = 1'b1;
        endcase
    end

    always_comb begin
        cmd.src1 = {src1_hi, src1_lo};
        cmd.src2 = {src2_hi, src2_lo};
        cmd.op   = div_op_e'(w_data_q[1:0]);
        cmd.is_w = w_data_q[2];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            aw_addr_q <= '0;
            w_data_q  <= '0;
            w_strb_q  <= '0;
            bvalid    <= 1'b0;
            bresp     <= axil_resp_ok;
        end else begin
            if (awvalid && awready) begin
                aw_full   <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_full   <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            if (wr_fire) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= wr_err ? axil_resp_slverr : axil_resp_ok;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src1_lo <= '0;
            src1_hi <= '0;
            src2_lo <= '0;
            src2_hi <= '0;
        end else if (wr_fire) begin
            case (wa)
                reg_src1_lo: src1_lo <= strb_merge(src1_lo, w_data_q, w_strb_q);
                reg_src1_hi: src1_hi <= strb_merge(src1_hi, w_data_q, w_strb_q);
                reg_src2_lo: src2_lo <= strb_merge(src2_lo, w_data_q, w_strb_q);
                reg_src2_hi: src2_hi <= strb_merge(src2_hi, w_data_q, w_strb_q);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= axil_resp_ok;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
            rresp  <= axil_resp_ok;
            case (ra)
                reg_src1_lo: rdata <= src1_lo;
                reg_src1_hi: rdata <= src1_hi;
                reg_src2_lo: rdata <= src2_lo;
                reg_src2_hi: rdata <= src2_hi;
                reg_status:  rdata <= {{(axil_dw-2){1'b0}}, done, busy};
                reg_res_lo:  rdata <= result[axil_dw-1:0];
                reg_res_hi:  rdata <= result[xlen-1:axil_dw];
                default: begin
                    rdata <= '0;  // reg_ctrl is write only.
                    rresp <= axil_resp_slverr;
                end
            endcase
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- logic/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl
    import div_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic load,
    output logic step,
    output logic finish,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_run  = 2'b01,
        st_fin  = 2'b10
    } state_e;

    state_e     state_q;
    logic [6:0] cnt_q;     // completed steps.
    logic       last_step;

    assign last_step = (cnt_q == 7'(div_steps - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= st_run;
                    end
                end
                st_run: begin
                    cnt_q <= cnt_q + 7'd1;
                    if (last_step) begin
                        state_q <= st_fin;
                    end
                end
                default: begin
                    state_q <= st_idle; // result gets captured this cycle.
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (finish) begin
            done <= 1'b1;
        end
    end

    assign load   = start && (state_q == st_idle);
    assign step   = (state_q == st_run);
    assign finish = (state_q == st_fin);
    assign busy   = (state_q != st_idle);

    // a run of steps only begins right after a load from idle.
    a_step_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(step) |-> $past(load));

    // load at cycle 0, steps in 1..64, finish in 65.
    a_finish_time: assert property (@(posedge clk) disable iff (!arst_n)
        load |=> !finish [*div_steps] ##1 finish);

endmodule

//--- logic/div_result_fix.sv
`timescale 1ns/1ps

module div_result_fix
    import div_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            finish,
    input  logic [xlen-1:0] quotient,
    input  logic [xlen-1:0] remainder,
    input  div_prep_t       meta,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] quot_fix;
    logic [xlen-1:0] rem_fix;
    logic [xlen-1:0] sel;
    logic [xlen-1:0] res_next;

    always_comb begin
        quot_fix = meta.quot_neg ? -quotient : quotient;
        if (meta.div_zero) begin
            quot_fix = '1;  // remainder is already the dividend here.
        end
        rem_fix  = meta.rem_neg ? -remainder : remainder;
        sel      = meta.op[1] ? rem_fix : quot_fix;
        if (meta.is_w) begin
            res_next = {{(xlen/2){sel[xlen/2-1]}}, sel[xlen/2-1:0]};
        end else begin
            res_next = sel;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (finish) begin
            result <= res_next;
        end
    end

endmodule

//--- logic/div_shift_sub.sv
`timescale 1ns/1ps

module div_shift_sub
    import div_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  logic            step,
    input  div_prep_t       prep,
    output logic [xlen-1:0] quotient,
    output logic [xlen-1:0] remainder,
    output div_prep_t       meta
);

    logic [2*xlen-1:0] rq_q;   // {partial remainder, dividend / quotient}.
    logic [xlen:0]     trial;
    logic              borrow;

    // trial subtract on the upper 65 bits, i.e. the remainder shifted left by one.
    assign trial  = rq_q[2*xlen-1:xlen-1] - {1'b0, meta.divisor_abs};
    assign borrow = trial[xlen];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rq_q <= '0;
        end else if (load) begin
            rq_q <= {{xlen{1'b0}}, prep.dividend_abs};
        end else if (step) begin
            if (borrow) begin
                rq_q <= {rq_q[2*xlen-2:0], 1'b0}; // restore, shift in 0.
            end else begin
                rq_q <= {trial[xlen-1:0], rq_q[xlen-2:0], 1'b1};
            end
        end
    end

    // divisor and sign info stay fixed for the whole operation.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta <= '0;
        end else if (load) begin
            meta <= prep;
        end
    end

    assign quotient  = rq_q[xlen-1:0];
    assign remainder = rq_q[2*xlen-1:xlen];

endmodule

//--- logic/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep
    import div_pkg::*;
(
    input  div_cmd_t  cmd,
    output div_prep_t prep
);

    logic [xlen-1:0] src1_ext;
    logic [xlen-1:0] src2_ext;
    logic            is_signed;
    logic            src1_neg;
    logic            src2_neg;

    assign is_signed = !cmd.op[0];

    always_comb begin
        if (cmd.is_w) begin
            // word forms only look at the low half.
            src1_ext = {{(xlen/2){is_signed & cmd.src1[xlen/2-1]}}, cmd.src1[xlen/2-1:0]};
            src2_ext = {{(xlen/2){is_signed & cmd.src2[xlen/2-1]}}, cmd.src2[xlen/2-1:0]};
        end else begin
            src1_ext = cmd.src1;
            src2_ext = cmd.src2;
        end
    end

    assign src1_neg = is_signed & src1_ext[xlen-1];
    assign src2_neg = is_signed & src2_ext[xlen-1];

    always_comb begin
        prep.dividend_abs = src1_neg ? -src1_ext : src1_ext; // min value maps to itself.
        prep.divisor_abs  = src2_neg ? -src2_ext : src2_ext;
        prep.quot_neg     = src1_neg ^ src2_neg;
        prep.rem_neg      = src1_neg;  // remainder follows the dividend sign.
        prep.div_zero     = (src2_ext == '0);
        prep.op           = cmd.op;
        prep.is_w         = cmd.is_w;
    end

endmodule

//--- logic/div_pkg.sv
package div_pkg;

    localparam int xlen      = 64;
    localparam int axil_aw   = 5;
    localparam int axil_dw   = 32;
    localparam int div_steps = 64;

    // bit 0 unsigned, bit 1 remainder.
    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_rem  = 2'b10,
        op_remu = 2'b11
    } div_op_e;

    localparam logic [axil_aw-1:0] reg_src1_lo = 5'h00;
    localparam logic [axil_aw-1:0] reg_src1_hi = 5'h04;
    localparam logic [axil_aw-1:0] reg_src2_lo = 5'h08;
    localparam logic [axil_aw-1:0] reg_src2_hi = 5'h0C;
    localparam logic [axil_aw-1:0] reg_ctrl    = 5'h10; // op, word flag, start.
    localparam logic [axil_aw-1:0] reg_status  = 5'h14; // busy, done.
    localparam logic [axil_aw-1:0] reg_res_lo  = 5'h18;
    localparam logic [axil_aw-1:0] reg_res_hi  = 5'h1C;

    localparam logic [1:0] axil_resp_ok     = 2'b00;
    localparam logic [1:0] axil_resp_slverr = 2'b10;

    typedef struct packed {
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        div_op_e         op;
        logic            is_w;
    } div_cmd_t;

    typedef struct packed {
        logic [xlen-1:0] dividend_abs;
        logic [xlen-1:0] divisor_abs;
        logic            quot_neg;     // quotient gets negated.
        logic            rem_neg;      // remainder gets negated.
        logic            div_zero;
        div_op_e         op;
        logic            is_w;
    } div_prep_t;

endpackage
